//--- build.f
common/cp0_arch_pkg.sv
common/cp0_bus_pkg.sv
logic/cp0_bus_port.sv
logic/cp0_exc_commit.sv
timer/cp0_timer.sv
regfile/cp0_regfile.sv
logic/cp0_top.sv
+incdir+sim
sim/tb_cp0.sv

//--- common/cp0_arch_pkg.sv
package cp0_arch_pkg;

    typedef logic [31:0] word_t;

    localparam int EXT_INT_W = 6;  // Hardware interrupt lines

    // Register selects are the {rd, sel} pair of mtc0/mfc0
    typedef enum logic [7:0] {
        REG_BADVADDR = 8'h40,  // rd 8, sel 0
        REG_COUNT    = 8'h48,  // rd 9, sel 0
        REG_COMPARE  = 8'h58,  // rd 11, sel 0
        REG_STATUS   = 8'h60,  // rd 12, sel 0
        REG_CAUSE    = 8'h68,  // rd 13, sel 0
        REG_EPC      = 8'h70,  // rd 14, sel 0
        REG_NONE     = 8'hff   // Any address that is not kept
    } cp0_reg_e;

    // Values are the Cause.ExcCode encodings
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,   // Load or fetch address error
        EXC_ADES = 5'd5,   // Store address error
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_TRAP = 5'd13
    } exc_code_e;

    // Status fields
    localparam int IM_MSB  = 15;
    localparam int IM_LSB  = 8;
    localparam int EXL_BIT = 1;
    localparam int IE_BIT  = 0;

    // Cause fields
    localparam int BD_BIT    = 31;
    localparam int TI_BIT    = 30;
    localparam int IP_MSB    = 15;
    localparam int IP_LSB    = 8;
    localparam int IP_SW_MSB = 9;  // Software interrupt bits
    localparam int IP_SW_LSB = 8;
    localparam int EXC_MSB   = 6;
    localparam int EXC_LSB   = 2;

endpackage

//--- common/cp0_bus_pkg.sv
package cp0_bus_pkg;

    import cp0_arch_pkg::*;

    // Wishbone classic request from the master
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [7:0] adr;  // {rd, sel}
        word_t      dat;
    } wb_req_t;

    // Register write issued by the bus port
    typedef struct packed {
        logic     valid;
        cp0_reg_e sel;
        word_t    data;
    } reg_wr_t;

    // Exception and ERET sideband from the pipeline
    typedef struct packed {
        logic      exc_valid;
        logic      eret;
        exc_code_e code;
        logic      bd;    // Instruction sits in a delay slot
        word_t     pc;
        word_t     addr;  // Faulting data address
    } exc_event_t;

    // Commit record handed from stage 1 to the register bank
    typedef struct packed {
        logic      exc;
        logic      eret;
        exc_code_e code;
        logic      bd_we;
        logic      bd;
        logic      epc_we;
        word_t     epc;
        logic      bva_we;
        word_t     bva;
    } exc_commit_t;

    typedef struct packed {
        logic       ie;
        logic       exl;
        logic [7:0] im;
        logic [7:0] ip;
        logic       ti;
        word_t      epc;
    } cp0_state_t;

endpackage

//--- logic/cp0_bus_port.sv
`timescale 1ns/100ps

module cp0_bus_port import cp0_arch_pkg::*, cp0_bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  wb_req_t  wb,
    input  word_t    rd_data,
    output cp0_reg_e rd_sel,
    output reg_wr_t  wr,
    output word_t    wb_dat_o,
    output logic     wb_ack
);

    logic req_new;

    // A request is new until it has been acked
    assign req_new = wb.cyc && wb.stb && !wb_ack;

    always_comb begin
        case (wb.adr)
            REG_BADVADDR,
            REG_COUNT,
            REG_COMPARE,
            REG_STATUS,
            REG_CAUSE,
            REG_EPC:  rd_sel = cp0_reg_e'(wb.adr);
            default:  rd_sel = REG_NONE;  // Dropped registers read zero
        endcase
    end

    always_comb begin
        wr.valid = req_new && wb.we;  // One write per request
        wr.sel   = rd_sel;
        wr.data  = wb.dat;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req_new;  // Single cycle ack
        end
    end

    // Read word holds until the next read
    always_ff @(posedge clk) begin
        if (req_new && !wb.we) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

//--- logic/cp0_exc_commit.sv
`timescale 1ns/100ps

module cp0_exc_commit import cp0_arch_pkg::*, cp0_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  exc_event_t  ev,
    input  logic        exl,
    output exc_commit_t commit,
    output logic        eret_flush
);

    logic        take_exc;
    logic        take_eret;
    logic        exl_ahead;
    logic        pc_misaligned;
    exc_commit_t commit_d;

    assign take_exc  = ev.exc_valid;
    assign take_eret = ev.eret && !ev.exc_valid;  // Exception wins over ERET

    // EXL as it will be once the record already in stage 2 lands
    assign exl_ahead = commit.exc ? 1'b1 : (commit.eret ? 1'b0 : exl);

    assign pc_misaligned = (ev.pc[1:0] != 2'b00);

    always_comb begin
        commit_d.exc    = take_exc;
        commit_d.eret   = take_eret;
        commit_d.code   = ev.code;
        commit_d.bd_we  = take_exc && !exl_ahead;  // Nested exceptions keep EPC and BD
        commit_d.bd     = ev.bd;
        commit_d.epc_we = take_exc && !exl_ahead;
        commit_d.epc    = ev.bd ? ev.pc - 32'd4 : ev.pc;  // Point back at the branch
        commit_d.bva_we = 1'b0;
        commit_d.bva    = ev.addr;
        if (take_exc) begin
            case (ev.code)
                EXC_ADEL: begin
                    commit_d.bva_we = 1'b1;
                    if (pc_misaligned) begin
                        commit_d.bva = ev.pc;  // Fetch from a bad pc
                    end
                end
                EXC_ADES: commit_d.bva_we = 1'b1;
                default:  commit_d.bva_we = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        commit <= commit_d;
        if (reset) begin
            commit.exc    <= 1'b0;
            commit.eret   <= 1'b0;
            commit.bd_we  <= 1'b0;
            commit.epc_we <= 1'b0;
            commit.bva_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eret_flush <= 1'b0;
        end else begin
            eret_flush <= take_eret;  // Flush pulse for the pipeline
        end
    end

endmodule

//--- logic/cp0_top.sv
`timescale 1ns/100ps

module cp0_top import cp0_arch_pkg::*, cp0_bus_pkg::*; #(
    parameter word_t COMPARE_RESET = 32'h000155cc
) (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_req_t              wb,
    output word_t                wb_dat_o,
    output logic                 wb_ack,
    input  exc_event_t           ev,
    input  logic [EXT_INT_W-1:0] ext_int,
    output cp0_state_t           state,
    output logic                 eret_flush
);

    cp0_reg_e    rd_sel;
    word_t       rd_data;
    reg_wr_t     wr;
    exc_commit_t commit;
    word_t       count;
    word_t       compare;
    logic        ti;

    // Stage 1, bus side
    cp0_bus_port u_bus_port (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb),
        .rd_data  (rd_data),
        .rd_sel   (rd_sel),
        .wr       (wr),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    // Stage 1, exception side
    cp0_exc_commit u_exc_commit (
        .clk        (clk),
        .reset      (reset),
        .ev         (ev),
        .exl        (state.exl),
        .commit     (commit),
        .eret_flush (eret_flush)
    );

    cp0_timer #(
        .COMPARE_RESET (COMPARE_RESET)
    ) u_timer (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .count   (count),
        .compare (compare),
        .ti      (ti)
    );

    cp0_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .commit  (commit),
        .ext_int (ext_int),
        .ti      (ti),
        .count   (count),
        .compare (compare),
        .rd_sel  (rd_sel),
        .rd_data (rd_data),
        .state   (state)
    );

endmodule

//--- regfile/cp0_regfile.sv
`timescale 1ns/100ps

module cp0_regfile import cp0_arch_pkg::*, cp0_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  reg_wr_t              wr,
    input  exc_commit_t          commit,
    input  logic [EXT_INT_W-1:0] ext_int,
    input  logic                 ti,
    input  word_t                count,
    input  word_t                compare,
    input  cp0_reg_e             rd_sel,
    output word_t                rd_data,
    output cp0_state_t           state
);

    logic [7:0] im;
    logic       exl;
    logic       ie;
    logic       bd;
    logic [5:0] ip_hw;  // IP7..IP2
    logic [1:0] ip_sw;  // IP1..IP0
    exc_code_e  exc_code;
    word_t      epc;
    word_t      bva;
    logic       wr_status;
    logic       wr_cause;
    logic       wr_epc;
    word_t      status_w;
    word_t      cause_w;

    assign wr_status = wr.valid && (wr.sel == REG_STATUS);
    assign wr_cause  = wr.valid && (wr.sel == REG_CAUSE);
    assign wr_epc    = wr.valid && (wr.sel == REG_EPC);

    always_ff @(posedge clk) begin
        if (reset) begin
            im <= '0;
            ie <= 1'b0;
        end else if (wr_status) begin
            im <= wr.data[IM_MSB:IM_LSB];
            ie <= wr.data[IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (commit.exc) begin
            exl <= 1'b1;
        end else if (commit.eret) begin
            exl <= 1'b0;
        end else if (wr_status) begin
            exl <= wr.data[EXL_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bd       <= 1'b0;
            exc_code <= EXC_INT;
        end else begin
            if (commit.bd_we) begin
                bd <= commit.bd;
            end
            if (commit.exc) begin
                exc_code <= commit.code;  // Updated even inside a handler
            end
        end
    end

    // Hardware lines sampled every edge, timer shares IP7
    always_ff @(posedge clk) begin
        if (reset) begin
            ip_hw <= '0;
        end else begin
            ip_hw <= {ext_int[5] | ti, ext_int[4:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip_sw <= '0;
        end else if (wr_cause) begin
            ip_sw <= wr.data[IP_SW_MSB:IP_SW_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (commit.epc_we) begin
            epc <= commit.epc;  // Commit beats a software write
        end else if (wr_epc) begin
            epc <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bva <= '0;
        end else if (commit.bva_we) begin
            bva <= commit.bva;
        end
    end

    always_comb begin
        status_w                 = '0;
        status_w[IM_MSB:IM_LSB]  = im;
        status_w[EXL_BIT]        = exl;
        status_w[IE_BIT]         = ie;
        cause_w                  = '0;
        cause_w[BD_BIT]          = bd;
        cause_w[TI_BIT]          = ti;
        cause_w[IP_MSB:IP_LSB]   = {ip_hw, ip_sw};
        cause_w[EXC_MSB:EXC_LSB] = exc_code;
    end

    always_comb begin
        case (rd_sel)
            REG_BADVADDR: rd_data = bva;
            REG_COUNT:    rd_data = count;
            REG_COMPARE:  rd_data = compare;
            REG_STATUS:   rd_data = status_w;
            REG_CAUSE:    rd_data = cause_w;
            REG_EPC:      rd_data = epc;
            default:      rd_data = '0;
        endcase
    end

    always_comb begin
        state.ie  = ie;
        state.exl = exl;
        state.im  = im;
        state.ip  = {ip_hw, ip_sw};
        state.ti  = ti;
        state.epc = epc;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the CP0 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module tb_cp0 -o tb_cp0_sim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

output=$(./obj_dir/tb_cp0_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found"
exit 1

//--- sim/tb_cp0_model.svh
`ifndef TB_CP0_MODEL_SVH
`define TB_CP0_MODEL_SVH

// Architectural {rd, sel} addresses
localparam logic [7:0] ADR_BADVADDR = {5'd8, 3'd0};
localparam logic [7:0] ADR_COUNT    = {5'd9, 3'd0};
localparam logic [7:0] ADR_COMPARE  = {5'd11, 3'd0};
localparam logic [7:0] ADR_STATUS   = {5'd12, 3'd0};
localparam logic [7:0] ADR_CAUSE    = {5'd13, 3'd0};
localparam logic [7:0] ADR_EPC      = {5'd14, 3'd0};

logic       m_tick;
word_t      m_count;
word_t      m_compare;
logic       m_ti;
logic [7:0] m_im;
logic       m_exl;
logic       m_ie;
logic       m_bd;
logic [4:0] m_code;
logic [5:0] m_ip_hw;   // IP7..IP2
logic [1:0] m_ip_sw;   // IP1..IP0
word_t      m_epc;
word_t      m_bva;
logic       m_ack;
word_t      m_dat;
logic       m_flush;
logic       c_exc;     // Record on its way to the register bank
logic       c_eret;
logic [4:0] c_code;
logic       c_upd;     // EPC and BD may change
logic       c_bd;
word_t      c_epc;
logic       c_bva_we;
word_t      c_bva;

function automatic word_t model_read(input logic [7:0] adr);
    case (adr)
        ADR_BADVADDR: return m_bva;
        ADR_COUNT:    return m_count;
        ADR_COMPARE:  return m_compare;
        ADR_STATUS:   return {16'h0, m_im, 6'h0, m_exl, m_ie};
        ADR_CAUSE:    return {m_bd, m_ti, 14'h0, m_ip_hw, m_ip_sw, 1'b0, m_code, 2'b00};
        ADR_EPC:      return m_epc;
        default:      return '0;
    endcase
endfunction

// One rising edge of the whole core
task automatic model_step();
    logic  req;
    logic  wr_v;
    word_t rd_word;
    logic  exl_ahead;
    if (reset) begin
        m_tick    = 1'b0;
        m_count   = '0;
        m_compare = COMPARE_RST;
        m_ti      = 1'b0;
        m_im      = '0;
        m_exl     = 1'b0;
        m_ie      = 1'b0;
        m_bd      = 1'b0;
        m_code    = '0;
        m_ip_hw   = '0;
        m_ip_sw   = '0;
        m_epc     = '0;
        m_bva     = '0;
        m_ack     = 1'b0;
        m_flush   = 1'b0;
        c_exc     = 1'b0;
        c_eret    = 1'b0;
        c_upd     = 1'b0;
        c_bva_we  = 1'b0;
    end else begin
        req       = wb.cyc && wb.stb && !m_ack;
        wr_v      = req && wb.we;
        rd_word   = model_read(wb.adr);      // Read mux before the edge
        exl_ahead = c_exc || (!c_eret && m_exl);
        if (c_exc) begin
            m_exl = 1'b1;
        end else if (c_eret) begin
            m_exl = 1'b0;
        end else if (wr_v && wb.adr == ADR_STATUS) begin
            m_exl = wb.dat[1];
        end
        if (wr_v && wb.adr == ADR_STATUS) begin
            m_im = wb.dat[15:8];
            m_ie = wb.dat[0];
        end
        if (c_upd) begin
            m_bd = c_bd;
        end
        if (c_exc) begin
            m_code = c_code;
        end
        if (c_upd) begin
            m_epc = c_epc;                   // Commit wins over the bus
        end else if (wr_v && wb.adr == ADR_EPC) begin
            m_epc = wb.dat;
        end
        if (c_bva_we) begin
            m_bva = c_bva;
        end
        m_ip_hw = {ext_int[5] | m_ti, ext_int[4:0]};
        if (wr_v && wb.adr == ADR_CAUSE) begin
            m_ip_sw = wb.dat[9:8];
        end
        if (wr_v && wb.adr == ADR_COMPARE) begin
            m_ti = 1'b0;
        end else if (m_count == m_compare) begin
            m_ti = 1'b1;
        end
        if (wr_v && wb.adr == ADR_COUNT) begin
            m_count = wb.dat;
        end else if (m_tick) begin
            m_count = m_count + 32'd1;
        end
        if (wr_v && wb.adr == ADR_COMPARE) begin
            m_compare = wb.dat;
        end
        m_tick = !m_tick;
        // New record from the event seen at this edge
        c_exc    = ev.exc_valid;
        c_eret   = ev.eret && !ev.exc_valid;
        c_code   = ev.code;
        c_upd    = ev.exc_valid && !exl_ahead;
        c_bd     = ev.bd;
        c_epc    = ev.bd ? ev.pc - 32'd4 : ev.pc;
        c_bva_we = ev.exc_valid && (ev.code == EXC_ADEL || ev.code == EXC_ADES);
        c_bva    = (ev.code == EXC_ADEL && ev.pc[1:0] != 2'b00) ? ev.pc : ev.addr;
        m_flush  = ev.eret && !ev.exc_valid;
        if (req && !wb.we) begin
            m_dat = rd_word;
        end
        m_ack = req;
    end
endtask

`endif

//--- sim/tb_cp0.sv
`timescale 1ns/100ps

module tb_cp0 import cp0_arch_pkg::*, cp0_bus_pkg::*; ();

    localparam int    PERIOD       = 20;
    localparam int    STIM_DELAY   = 2;
    localparam int    RESET_CYCLES = 8;
    localparam int    NUM_CYCLES   = 5000;
    localparam word_t COMPARE_RST  = 32'd40;

    localparam exc_code_e CODES [8] = '{EXC_INT, EXC_ADEL, EXC_ADES, EXC_SYS,
                                        EXC_BP, EXC_RI, EXC_OV, EXC_TRAP};

    logic                 clk;
    logic                 reset;
    wb_req_t              wb;
    word_t                wb_dat_o;
    logic                 wb_ack;
    exc_event_t           ev;
    logic [EXT_INT_W-1:0] ext_int;
    cp0_state_t           state;
    logic                 eret_flush;
    word_t                rng;
    logic                 bus_active;  // Request waiting for its ack

    `include "tb_cp0_model.svh"

    cp0_top #(
        .COMPARE_RESET (COMPARE_RST)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .wb         (wb),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .ev         (ev),
        .ext_int    (ext_int),
        .state      (state),
        .eret_flush (eret_flush)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic word_t next_random();
        word_t x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic check(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [7:0] pick_address(input word_t r);
        case (r[2:0])
            3'd0:    return ADR_BADVADDR;
            3'd1:    return ADR_COUNT;
            3'd2:    return ADR_COMPARE;
            3'd3:    return ADR_STATUS;
            3'd4:    return ADR_CAUSE;
            3'd5:    return ADR_EPC;
            default: return r[15:8];  // Mostly unused addresses
        endcase
    endfunction

    task automatic check_outputs();
        check(32'(wb_ack), 32'(bus_active), "wb_ack one cycle after the request");
        if (bus_active && !wb.we) begin
            check(wb_dat_o, m_dat, $sformatf("read data at address %h", wb.adr));
        end
        check(32'(eret_flush), 32'(m_flush), "eret_flush");
        check(32'(state.ie), 32'(m_ie), "state.ie");
        check(32'(state.exl), 32'(m_exl), "state.exl");
        check(32'(state.im), 32'(m_im), "state.im");
        check(32'(state.ip), {24'h0, m_ip_hw, m_ip_sw}, "state.ip");
        check(32'(state.ti), 32'(m_ti), "state.ti");
        check(state.epc, m_epc, "state.epc");
    endtask

    task automatic drive_inputs();
        word_t r;
        r       = next_random();
        ext_int = r[5:0];
        if (bus_active) begin
            wb.cyc     = 1'b0;  // Idle for one cycle after the ack
            wb.stb     = 1'b0;
            bus_active = 1'b0;
        end else if (r[8:6] < 3'd3) begin
            wb.cyc = 1'b1;
            wb.stb = 1'b1;
            wb.we  = r[9];
            wb.adr = pick_address(next_random());
            wb.dat = next_random();
            if (wb.adr == ADR_COUNT || wb.adr == ADR_COMPARE) begin
                wb.dat = wb.dat & 32'h3f;  // Keep Count near Compare
            end
            bus_active = 1'b1;
        end
        r            = next_random();
        ev.exc_valid = (r[2:0] == 3'd0);
        ev.eret      = (r[5:3] == 3'd0);
        ev.code      = CODES[r[8:6]];
        ev.bd        = r[9];
        ev.pc        = next_random();
        if (r[10]) begin
            ev.pc[1:0] = 2'b00;
        end
        ev.addr = next_random();
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        wb         = '0;
        ev         = '0;
        ext_int    = '0;
        rng        = 32'd62;
        bus_active = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #STIM_DELAY;
            model_step();
        end
        reset = 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            #STIM_DELAY;
            model_step();
            check_outputs();
            drive_inputs();
        end
        $display("Everything OK");
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 100) * PERIOD);
        $display("Timeout: the test did not reach its end in time");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- timer/cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer import cp0_arch_pkg::*, cp0_bus_pkg::*; #(
    parameter word_t COMPARE_RESET = 32'h000155cc
) (
    input  logic    clk,
    input  logic    reset,
    input  reg_wr_t wr,
    output word_t   count,
    output word_t   compare,
    output logic    ti
);

    logic tick;
    logic wr_count;
    logic wr_compare;

    assign wr_count   = wr.valid && (wr.sel == REG_COUNT);
    assign wr_compare = wr.valid && (wr.sel == REG_COMPARE);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;  // Count runs at half the clock rate
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (wr_count) begin
            count <= wr.data;  // Software write beats the increment
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= COMPARE_RESET;
        end else if (wr_compare) begin
            compare <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (wr_compare) begin
            ti <= 1'b0;  // Writing Compare acknowledges the timer
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

endmodule
